//--- verilog/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// data memory word address width, 64 words
`define DMEM_ADDR_BITS 6

// architectural register count
`define REG_COUNT 32

`endif

//--- verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef enum logic [5:0] {
        RType = 6'h00,
        J     = 6'h02,
        BEQ   = 6'h04,
        BNE   = 6'h05,
        LW    = 6'h23,
        SW    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        JR   = 6'h08,
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } functT;

    // add for load/store, sub for branches, funct field for R-type
    typedef enum logic [1:0] {
        OpAdd   = 2'b00,
        OpSub   = 2'b01,
        OpFunct = 2'b10
    } aluOpT;

    typedef enum logic [2:0] {
        FnNop = 3'd0,
        FnAdd = 3'd1,
        FnSub = 3'd2,
        FnAnd = 3'd3,
        FnOr  = 3'd4,
        FnSlt = 3'd5
    } aluFnT;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFmtT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFmtT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } jFmtT;

    // one instruction word, three field layouts
    typedef union packed {
        rFmtT r;
        iFmtT i;
        jFmtT j;
    } instrWordT;

    typedef struct packed {
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic        branch;
        logic        branchNe;
        logic        jump;
        logic        jumpRegister;
        aluFnT       aluFn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        // sign-extended imm16, or the zero-extended index for j
        logic [31:0] imm;
    } decodedT;

    typedef struct packed {
        decodedT     dec;
        logic [31:0] opA;
        logic [31:0] opB;
    } operandT;

    typedef struct packed {
        logic        regWrite;
        logic        memRead;
        logic        memWrite;
        logic [4:0]  dest;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic        taken;
        logic [31:0] target;
    } executeT;

    typedef struct packed {
        logic        regWrite;
        logic [4:0]  dest;
        logic [31:0] value;
        logic        memWrite;
        logic [31:0] addr;
        logic        taken;
        logic [31:0] target;
    } writebackT;

endpackage

`default_nettype wire

//--- verilog/pipeIf.sv
`default_nettype none

// valid/ready link between two pipeline stages
interface pipeIf #(
    parameter type T = logic
);
    logic        valid;
    logic        ready;
    logic [31:0] pc;
    T            data;

    modport src (
        output valid,
        output pc,
        output data,
        input  ready
    );

    modport dst (
        input  valid,
        input  pc,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

//--- verilog/opcodeControl.sv
`default_nettype none

module opcodeControl (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrValid,
    input  logic [31:0] instrPc,
    input  logic [31:0] instrWord,
    output logic        instrReady,
    pipeIf.src          down
);
    mipsPkg::instrWordT iw;
    logic               isR;
    logic               isJ;
    logic               isJr;
    logic               isBeq;
    logic               isBne;
    logic               isLw;
    logic               isSw;
    logic               fnKnown;
    mipsPkg::aluFnT     fnFromFunct;
    mipsPkg::aluOpT     aluOp;
    mipsPkg::decodedT   dec;
    logic               accept;

    assign iw = instrWord;

    // one-hot instruction class
    always_comb begin
        isR   = 1'b0;
        isJ   = 1'b0;
        isBeq = 1'b0;
        isBne = 1'b0;
        isLw  = 1'b0;
        isSw  = 1'b0;
        case (iw.r.opcode)
            mipsPkg::RType: isR = 1'b1;
            mipsPkg::J:     isJ = 1'b1;
            mipsPkg::BEQ:   isBeq = 1'b1;
            mipsPkg::BNE:   isBne = 1'b1;
            mipsPkg::LW:    isLw = 1'b1;
            mipsPkg::SW:    isSw = 1'b1;
            default:        ;
        endcase
    end

    // funct field, only meaningful for R-type
    always_comb begin
        isJr        = 1'b0;
        fnKnown     = 1'b1;
        fnFromFunct = mipsPkg::FnNop;
        case (iw.r.funct)
            mipsPkg::ADD,
            mipsPkg::ADDU: fnFromFunct = mipsPkg::FnAdd;
            mipsPkg::SUB,
            mipsPkg::SUBU: fnFromFunct = mipsPkg::FnSub;
            mipsPkg::AND:  fnFromFunct = mipsPkg::FnAnd;
            mipsPkg::OR:   fnFromFunct = mipsPkg::FnOr;
            mipsPkg::SLT:  fnFromFunct = mipsPkg::FnSlt;
            mipsPkg::JR: begin
                isJr    = isR;
                fnKnown = 1'b0;
            end
            default: fnKnown = 1'b0;
        endcase
    end

    always_comb begin
        case (iw.r.opcode)
            mipsPkg::RType: aluOp = mipsPkg::OpFunct;
            mipsPkg::BEQ,
            mipsPkg::BNE:   aluOp = mipsPkg::OpSub;
            default:        aluOp = mipsPkg::OpAdd;
        endcase
    end

    always_comb begin
        dec.regWrite     = (isR && fnKnown) || isLw;
        dec.memRead      = isLw;
        dec.memWrite     = isSw;
        dec.branch       = isBeq;
        dec.branchNe     = isBne;
        dec.jump         = isJ;
        dec.jumpRegister = isJr;
        case (aluOp)
            mipsPkg::OpSub:   dec.aluFn = mipsPkg::FnSub;
            mipsPkg::OpFunct: dec.aluFn = fnFromFunct;
            default:          dec.aluFn = mipsPkg::FnAdd;
        endcase
        dec.rs = iw.r.rs;
        dec.rt = iw.r.rt;
        // rd for R-type, rt for loads, nothing else writes
        if (isR && fnKnown) begin
            dec.dest = iw.r.rd;
        end else if (isLw) begin
            dec.dest = iw.i.rt;
        end else begin
            dec.dest = 5'd0;
        end
        if (isJ) begin
            dec.imm = {6'd0, iw.j.index};
        end else begin
            dec.imm = {{16{iw.i.imm[15]}}, iw.i.imm};
        end
    end

    assign instrReady = !down.valid || down.ready;
    assign accept     = instrValid && instrReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            down.valid <= 1'b0;
        end else if (instrReady) begin
            down.valid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            down.data <= dec;
            down.pc   <= instrPc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/operandFetch.sv
`default_nettype none

`include "mips_config.svh"

module operandFetch (
    input  logic        clk,
    input  logic        arstN,
    pipeIf.dst          up,
    pipeIf.src          down,
    input  logic        wbEnable,
    input  logic [4:0]  wbDest,
    input  logic [31:0] wbValue
);
    logic [31:0]            regFile [`REG_COUNT];
    logic [`REG_COUNT-1:0]  pending;
    logic [`REG_COUNT-1:0]  setMask;
    logic [`REG_COUNT-1:0]  clrMask;
    logic                   useRs;
    logic                   useRt;
    logic                   hazard;
    logic                   stageReady;
    logic                   accept;
    logic [31:0]            rsValue;
    logic [31:0]            rtValue;
    mipsPkg::operandT       opnd;

    // j carries its index in the rs/rt bits
    assign useRs = !up.data.jump;
    assign useRt = (up.data.regWrite && !up.data.memRead) || up.data.memWrite
                   || up.data.branch || up.data.branchNe;

    // sources wait for their writer, a second writer waits for the first
    assign hazard = (useRs && pending[up.data.rs])
                    || (useRt && pending[up.data.rt])
                    || (up.data.regWrite && pending[up.data.dest]);

    assign stageReady = !down.valid || down.ready;
    assign up.ready   = stageReady && !hazard;
    assign accept     = up.valid && up.ready;

    // r0 always reads zero
    assign rsValue = (up.data.rs == 5'd0) ? 32'd0 : regFile[up.data.rs];
    assign rtValue = (up.data.rt == 5'd0) ? 32'd0 : regFile[up.data.rt];

    always_comb begin
        opnd.dec = up.data;
        opnd.opA = rsValue;
        opnd.opB = rtValue;
    end

    always_comb begin
        setMask = '0;
        clrMask = '0;
        if (accept && up.data.regWrite && up.data.dest != 5'd0) begin
            setMask[up.data.dest] = 1'b1;
        end
        if (wbEnable) begin
            clrMask[wbDest] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pending <= '0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                regFile[i] <= 32'd0;
            end
        end else begin
            pending <= (pending & ~clrMask) | setMask;
            if (wbEnable) begin
                regFile[wbDest] <= wbValue;
            end
        end
    end

    // a stalled instruction leaves a bubble behind it
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            down.valid <= 1'b0;
        end else if (stageReady) begin
            down.valid <= up.valid && !hazard;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            down.data <= opnd;
            down.pc   <= up.pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/aluExecute.sv
`default_nettype none

module aluExecute (
    input  logic clk,
    input  logic arstN,
    pipeIf.dst   up,
    pipeIf.src   down
);
    mipsPkg::decodedT dec;
    logic [31:0]      opA;
    logic [31:0]      opB;
    logic [31:0]      srcB;
    logic [31:0]      pcPlus4;
    logic [31:0]      aluResult;
    logic [31:0]      target;
    logic             zero;
    logic             taken;
    logic             accept;
    mipsPkg::executeT ex;

    assign dec     = up.data.dec;
    assign opA     = up.data.opA;
    assign opB     = up.data.opB;
    assign pcPlus4 = up.pc + 32'd4;

    // loads and stores add the offset to the base
    assign srcB = (dec.memRead || dec.memWrite) ? dec.imm : opB;

    always_comb begin
        case (dec.aluFn)
            mipsPkg::FnAdd: aluResult = opA + srcB;
            mipsPkg::FnSub: aluResult = opA - srcB;
            mipsPkg::FnAnd: aluResult = opA & srcB;
            mipsPkg::FnOr:  aluResult = opA | srcB;
            mipsPkg::FnSlt: aluResult = {31'd0, $signed(opA) < $signed(srcB)};
            default:        aluResult = 32'd0;
        endcase
    end

    assign zero  = (aluResult == 32'd0);
    assign taken = (dec.branch && zero) || (dec.branchNe && !zero)
                   || dec.jump || dec.jumpRegister;

    always_comb begin
        if (dec.jumpRegister) begin
            target = opA;
        end else if (dec.jump) begin
            target = {pcPlus4[31:28], dec.imm[25:0], 2'b00};
        end else if (dec.branch || dec.branchNe) begin
            target = pcPlus4 + {dec.imm[29:0], 2'b00};
        end else begin
            target = 32'd0;
        end
    end

    always_comb begin
        ex.regWrite  = dec.regWrite;
        ex.memRead   = dec.memRead;
        ex.memWrite  = dec.memWrite;
        ex.dest      = dec.dest;
        ex.aluResult = aluResult;
        ex.storeData = opB;
        ex.taken     = taken;
        ex.target    = target;
    end

    assign up.ready = !down.valid || down.ready;
    assign accept   = up.valid && up.ready;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            down.valid <= 1'b0;
        end else if (up.ready) begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            down.data <= ex;
            down.pc   <= up.pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/memAccess.sv
`default_nettype none

`include "mips_config.svh"

module memAccess (
    input  logic        clk,
    input  logic        arstN,
    pipeIf.dst          up,
    output logic        resultValid,
    input  logic        resultReady,
    output logic [31:0] resultPc,
    output logic        resultRegWrite,
    output logic [4:0]  resultDest,
    output logic [31:0] resultValue,
    output logic        resultMemWrite,
    output logic [31:0] resultAddr,
    output logic        resultTaken,
    output logic [31:0] resultTarget,
    output logic        wbEnable,
    output logic [4:0]  wbDest,
    output logic [31:0] wbValue
);
    logic [31:0]                dmem [2**`DMEM_ADDR_BITS];
    logic [`DMEM_ADDR_BITS-1:0] wordAddr;
    logic                       accept;
    logic                       isMem;
    mipsPkg::executeT           ex;
    mipsPkg::writebackT         rec;
    mipsPkg::writebackT         recQ;

    assign ex       = up.data;
    assign wordAddr = ex.aluResult[`DMEM_ADDR_BITS+1:2];
    assign isMem    = ex.memRead || ex.memWrite;

    assign up.ready = !resultValid || resultReady;
    assign accept   = up.valid && up.ready;

    always_comb begin
        rec.regWrite = ex.regWrite;
        rec.dest     = ex.dest;
        if (!ex.regWrite) begin
            rec.value = 32'd0;
        end else if (ex.memRead) begin
            rec.value = dmem[wordAddr];
        end else begin
            rec.value = ex.aluResult;
        end
        rec.memWrite = ex.memWrite;
        rec.addr     = isMem ? ex.aluResult : 32'd0;
        rec.taken    = ex.taken;
        rec.target   = ex.target;
    end

    always_ff @(posedge clk) begin
        if (accept && ex.memWrite) begin
            dmem[wordAddr] <= ex.storeData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
        end else if (up.ready) begin
            resultValid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            recQ     <= rec;
            resultPc <= up.pc;
        end
    end

    assign resultRegWrite = recQ.regWrite;
    assign resultDest     = recQ.dest;
    assign resultValue    = recQ.value;
    assign resultMemWrite = recQ.memWrite;
    assign resultAddr     = recQ.addr;
    assign resultTaken    = recQ.taken;
    assign resultTarget   = recQ.target;

    // register write retires with the result transfer, r0 dropped
    assign wbEnable = resultValid && resultReady && recQ.regWrite && recQ.dest != 5'd0;
    assign wbDest   = recQ.dest;
    assign wbValue  = recQ.value;

endmodule

`default_nettype wire

//--- verilog/mipsPipeline.sv
`default_nettype none

module mipsPipeline (
    input  logic        clk,
    input  logic        arstN,
    input  logic        instrValid,
    output logic        instrReady,
    input  logic [31:0] instrPc,
    input  logic [31:0] instrWord,
    output logic        resultValid,
    input  logic        resultReady,
    output logic [31:0] resultPc,
    output logic        resultRegWrite,
    output logic [4:0]  resultDest,
    output logic [31:0] resultValue,
    output logic        resultMemWrite,
    output logic [31:0] resultAddr,
    output logic        resultTaken,
    output logic [31:0] resultTarget
);
    logic        wbEnable;
    logic [4:0]  wbDest;
    logic [31:0] wbValue;

    pipeIf #(.T(mipsPkg::decodedT)) decIf ();
    pipeIf #(.T(mipsPkg::operandT)) opIf ();
    pipeIf #(.T(mipsPkg::executeT)) exIf ();

    opcodeControl decode0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrPc    (instrPc),
        .instrWord  (instrWord),
        .instrReady (instrReady),
        .down       (decIf.src)
    );

    // register read, stalls on pending writes
    operandFetch fetch0 (
        .clk      (clk),
        .arstN    (arstN),
        .up       (decIf.dst),
        .down     (opIf.src),
        .wbEnable (wbEnable),
        .wbDest   (wbDest),
        .wbValue  (wbValue)
    );

    aluExecute execute0 (
        .clk   (clk),
        .arstN (arstN),
        .up    (opIf.dst),
        .down  (exIf.src)
    );

    memAccess mem0 (
        .clk            (clk),
        .arstN          (arstN),
        .up             (exIf.dst),
        .resultValid    (resultValid),
        .resultReady    (resultReady),
        .resultPc       (resultPc),
        .resultRegWrite (resultRegWrite),
        .resultDest     (resultDest),
        .resultValue    (resultValue),
        .resultMemWrite (resultMemWrite),
        .resultAddr     (resultAddr),
        .resultTaken    (resultTaken),
        .resultTarget   (resultTarget),
        .wbEnable       (wbEnable),
        .wbDest         (wbDest),
        .wbValue        (wbValue)
    );

endmodule

`default_nettype wire

//--- verif/mipsChecker.sv
`default_nettype none

module mipsChecker #(
    parameter int RecWords = 9,
    parameter int PatWords = 288
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        resultValid,
    input  logic        resultReady,
    input  logic [31:0] resultPc,
    input  logic        resultRegWrite,
    input  logic [4:0]  resultDest,
    input  logic [31:0] resultValue,
    input  logic        resultMemWrite,
    input  logic [31:0] resultAddr,
    input  logic        resultTaken,
    input  logic [31:0] resultTarget,
    input  logic [31:0] patterns [PatWords],
    input  int          numTests,
    output int          resultCount,
    output int          errorCount
);
    timeunit 1ns;
    timeprecision 100ps;

    mipsPkg::writebackT gotRec;
    mipsPkg::writebackT expRec;
    logic [31:0]        expPc;

    // pattern columns after pc and word are rw, dest, value, mw, addr, taken and target
    function automatic mipsPkg::writebackT expectedRecord(input int idx);
        mipsPkg::writebackT rec;
        int                 b;
        b            = idx * RecWords;
        rec.regWrite = patterns[b + 2][0];
        rec.dest     = patterns[b + 3][4:0];
        rec.value    = patterns[b + 4];
        rec.memWrite = patterns[b + 5][0];
        rec.addr     = patterns[b + 6];
        rec.taken    = patterns[b + 7][0];
        rec.target   = patterns[b + 8];
        return rec;
    endfunction

    always_comb begin
        gotRec.regWrite = resultRegWrite;
        gotRec.dest     = resultDest;
        gotRec.value    = resultValue;
        gotRec.memWrite = resultMemWrite;
        gotRec.addr     = resultAddr;
        gotRec.taken    = resultTaken;
        gotRec.target   = resultTarget;
    end

    // results must arrive in program order
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultCount <= 0;
            errorCount  <= 0;
        end else if (resultValid && resultReady) begin
            if (resultCount >= numTests) begin
                $display("extra result with pc %h after the last test at %0d ns",
                         resultPc, $time);
                errorCount <= errorCount + 1;
            end else begin
                expRec = expectedRecord(resultCount);
                expPc  = patterns[resultCount * RecWords];
                if (resultPc !== expPc || gotRec !== expRec) begin
                    $write("Fail at %0d ns: test %0d pc %h rw %0b rd %0d val %h",
                           $time, resultCount, resultPc, gotRec.regWrite, gotRec.dest,
                           gotRec.value);
                    $write(" mw %0b addr %h tk %0b tgt %h, expected pc %h",
                           gotRec.memWrite, gotRec.addr, gotRec.taken, gotRec.target,
                           expPc);
                    $display(" rw %0b rd %0d val %h mw %0b addr %h tk %0b tgt %h",
                             expRec.regWrite, expRec.dest, expRec.value, expRec.memWrite,
                             expRec.addr, expRec.taken, expRec.target);
                    errorCount <= errorCount + 1;
                end else begin
                    $display("test %0d pc %h passed", resultCount, resultPc);
                end
            end
            resultCount <= resultCount + 1;
        end
    end

endmodule

`default_nettype wire

//--- verif/mipsPipeline_assertions.sv
`default_nettype none

module mipsPipelineAssertions (
    input logic        clk,
    input logic        arstN,
    input logic        instrValid,
    input logic        instrReady,
    input logic        resultValid,
    input logic        resultReady,
    input logic [31:0] resultPc,
    input logic        resultRegWrite,
    input logic [4:0]  resultDest,
    input logic [31:0] resultValue,
    input logic        resultMemWrite,
    input logic [31:0] resultAddr,
    input logic        resultTaken,
    input logic [31:0] resultTarget
);
    timeunit 1ns;
    timeprecision 100ps;

    // a stalled result keeps valid and every field
    resultHeld: assert property (
        @(posedge clk) disable iff (!arstN)
        resultValid && !resultReady |=> resultValid
            && $stable({resultPc, resultRegWrite, resultDest, resultValue,
                        resultMemWrite, resultAddr, resultTaken, resultTarget})
    ) else $error("result changed while resultReady was low");

    resetQuiet: assert property (@(posedge clk) !arstN |-> !resultValid)
        else $error("resultValid high during reset");

    noResetAccept: assert property (@(posedge clk) !arstN |-> !(instrValid && instrReady))
        else $error("instruction accepted during reset");

endmodule

bind mipsPipeline mipsPipelineAssertions assert0 (.*);

`default_nettype wire

//--- verif/mipsPipelineTb.sv
`default_nettype none

module mipsPipelineTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RecWords = 9;
    localparam int MaxTests = 32;
    localparam int PatWords = RecWords * MaxTests;

    logic        clk;
    logic        arstN;
    logic        instrValid;
    logic        instrReady;
    logic [31:0] instrPc;
    logic [31:0] instrWord;
    logic        resultValid;
    logic        resultReady;
    logic [31:0] resultPc;
    logic        resultRegWrite;
    logic [4:0]  resultDest;
    logic [31:0] resultValue;
    logic        resultMemWrite;
    logic [31:0] resultAddr;
    logic        resultTaken;
    logic [31:0] resultTarget;
    logic [31:0] patterns [PatWords];
    logic [31:0] rngState;
    logic        loaded;
    int          numTests;
    int          resultCount;
    int          errorCount;

    mipsPipeline dut0 (.*);

    mipsChecker #(
        .RecWords (RecWords),
        .PatWords (PatWords)
    ) check0 (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // fill word tied to the full array index
    function automatic logic [31:0] fillWord(input int addr);
        return 32'hffff_ffff ^ 32'(addr);
    endfunction

    // records end at the first pc still holding its fill value
    function automatic int countRecords();
        int n;
        n = 0;
        while (n < MaxTests && patterns[n * RecWords] != fillWord(n * RecWords)) begin
            n++;
        end
        return n;
    endfunction

    task automatic driveInstr(input int idx);
        @(negedge clk);
        instrValid = 1'b1;
        instrPc    = patterns[idx * RecWords];
        instrWord  = patterns[idx * RecWords + 1];
        // hold until decode takes it
        do begin
            @(posedge clk);
        end while (!instrReady);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // random back-pressure on the result port
    initial begin
        resultReady = 1'b0;
        rngState    = 32'hfe0f;
        forever begin
            @(negedge clk);
            rngState    = xorshift(rngState);
            resultReady = (rngState % 32'd10) >= 32'd3;
        end
    end

    initial begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instrPc    = 32'd0;
        instrWord  = 32'd0;
        loaded     = 1'b0;
        for (int i = 0; i < PatWords; i++) begin
            patterns[i] = fillWord(i);
        end
        $readmemh("verif/mipsPipeline_patterns.hex", patterns);
        numTests = countRecords();
        loaded   = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        for (int i = 0; i < numTests; i++) begin
            driveInstr(i);
        end
        @(negedge clk);
        instrValid = 1'b0;
        wait (resultCount >= numTests);
        // room for a stray extra result to show up
        repeat (20) @(posedge clk);
        $display("%0d tests, %0d results, %0d errors", numTests, resultCount, errorCount);
        if (errorCount == 0 && resultCount == numTests && numTests > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // limit scales with the number of records
    initial begin
        wait (loaded && arstN);
        repeat (numTests * 40) @(posedge clk);
        $display("timeout: only %0d of %0d results arrived within %0d cycles",
                 resultCount, numTests, numTests * 40);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/mipsPipeline_patterns.hex
// pc       word     rw dest value    mw addr     tk target
// one instruction per line, its expected result record after the word
40000000 00004020 1 08 00000000 0 00000000 0 00000000
40000004 01084821 1 09 00000000 0 00000000 0 00000000
40000008 01285022 1 0a 00000000 0 00000000 0 00000000
4000000c 01495823 1 0b 00000000 0 00000000 0 00000000
40000010 016a6024 1 0c 00000000 0 00000000 0 00000000
40000014 018b6825 1 0d 00000000 0 00000000 0 00000000
40000018 01ac702a 1 0e 00000000 0 00000000 0 00000000
4000001c 01cd0020 1 00 00000000 0 00000000 0 00000000
40000020 ad0e0024 0 00 00000000 1 00000024 0 00000000
40000024 8d2f0024 1 0f 00000000 0 00000024 0 00000000
40000028 11e0fffd 0 00 00000000 0 00000000 1 40000020
4000002c 15e80005 0 00 00000000 0 00000000 0 40000044
40000030 08100040 0 00 00000000 0 00000000 1 40400100
40000034 01a00008 0 00 00000000 0 00000000 1 00000000
40000038 20051234 0 00 00000000 0 00000000 0 00000000
4000003c 00223800 0 00 00000000 0 00000000 0 00000000
40000040 01ef8020 1 10 00000000 0 00000000 0 00000000

//--- mipsPipeline.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/pipeIf.sv
verilog/opcodeControl.sv
verilog/operandFetch.sv
verilog/aluExecute.sv
verilog/memAccess.sv
verilog/mipsPipeline.sv
verif/mipsChecker.sv
verif/mipsPipeline_assertions.sv
verif/mipsPipelineTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := mipsPipelineTb
FILELIST  := mipsPipeline.f
OBJDIR    := obj_dir
LOG       := sim.log
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh verif/*.sv verif/*.hex)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "simulation ended without a verdict"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
